// File: source/peak_cfg_pkg.sv
// fixed build-time constants; window, burst and threshold multiplier must stay powers of two
`default_nettype none

//////////////////////////////////////////////////////////////////////
// design constants
//////////////////////////////////////////////////////////////////////

package peak_cfg_pkg;

  // antenna channels per frame
  localparam int NUM_CHANNELS = 4;
  // signed sample width per channel
  localparam int SAMPLE_WIDTH = 16;

  // boxcar window as log2 and as length
  localparam int AVG_POWER  = 4;
  localparam int AVG_LENGTH = 1 << AVG_POWER;
  // magnitude under test sits mid-window
  localparam int CENTER_DELAY = AVG_LENGTH / 2;

  // threshold multiplier is 1 << THRESH_SHIFT
  localparam int THRESH_SHIFT = 3;

  // raw frames per captured burst
  localparam int BURST_LENGTH = 16;
  // one extra bit so the counter can hold BURST_LENGTH itself
  localparam int COUNT_WIDTH = $clog2(BURST_LENGTH) + 1;

endpackage

`default_nettype wire

// File: source/peak_types_pkg.sv
// vector and frame types sized from peak_cfg_pkg; channel 0 sits in the low bits of a frame
`default_nettype none

//////////////////////////////////////////////////////////////////////
// shared types
//////////////////////////////////////////////////////////////////////

package peak_types_pkg;

  import peak_cfg_pkg::*;

  // one signed channel sample
  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  // magnitude, saturated to the largest positive sample
  typedef logic [SAMPLE_WIDTH-1:0] mag_t;

  // running window sum, room for AVG_LENGTH magnitudes
  typedef logic [SAMPLE_WIDTH+AVG_POWER-1:0] sum_t;

  // (avg + 1) << THRESH_SHIFT without overflow
  typedef logic [SAMPLE_WIDTH+THRESH_SHIFT-1:0] thresh_t;

  // burst, fill and drain counts
  typedef logic [COUNT_WIDTH-1:0] count_t;

  // raw frame, all channels sampled together
  typedef struct packed {
    sample_t [NUM_CHANNELS-1:0] ch;
  } frame_t;

  // per-channel magnitudes or averages
  typedef struct packed {
    mag_t [NUM_CHANNELS-1:0] ch;
  } mag_frame_t;

  // capture side: history filling or burst draining
  typedef enum logic {
    FILL  = 1'b0,
    DRAIN = 1'b1
  } capture_state_t;

endpackage

`default_nettype wire

// File: source/sample_ingress.sv
// keeps one accepted frame until it steps into the pipeline; in_ready is low while capture holds
`timescale 1ns/1ns
`default_nettype none

module sample_ingress
  import peak_cfg_pkg::*;
  import peak_types_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n,
  input  wire         in_valid,
  input  wire frame_t in_frame,
  input  wire         hold,
  output logic        in_ready,
  output logic        step,
  output frame_t      raw,
  output mag_frame_t  mag
);

  logic accept;
  logic pend_q;

  //////////////////////////////////////////////////////////////////////
  // handshake and step
  //////////////////////////////////////////////////////////////////////

  assign in_ready = ~hold;
  assign accept   = in_valid & in_ready;

  // a frame taken just before hold rises waits here until the drain ends
  assign step = pend_q & ~hold;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= 1'b0;
    end else if (accept) begin
      pend_q <= 1'b1;
    end else if (step) begin
      pend_q <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // raw and magnitude registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      raw <= in_frame;
      for (int i = 0; i < NUM_CHANNELS; i++) begin
        // most negative code has no positive twin
        if (in_frame.ch[i] == {1'b1, {(SAMPLE_WIDTH-1){1'b0}}}) begin
          mag.ch[i] <= {1'b0, {(SAMPLE_WIDTH-1){1'b1}}};
        end else if (in_frame.ch[i][SAMPLE_WIDTH-1]) begin
          mag.ch[i] <= mag_t'(-in_frame.ch[i]);
        end else begin
          mag.ch[i] <= mag_t'(in_frame.ch[i]);
        end
      end
    end
  end

  // source keeps its frame while stalled
  assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && !in_ready |=> !in_valid || $stable(in_frame));

endmodule

`default_nettype wire

// File: source/boxcar_average.sv
// window sums start from zero history so early averages are low; avg covers frames k-15..k
`timescale 1ns/1ns
`default_nettype none

module boxcar_average
  import peak_cfg_pkg::*;
  import peak_types_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,
  input  wire             step,
  input  wire frame_t     raw_in,
  input  wire mag_frame_t mag_in,
  output frame_t          raw_out,
  output mag_frame_t      mag_out,
  output mag_frame_t      avg
);

  // hist_q[0] newest, last entry leaves the window next
  mag_frame_t hist_q [AVG_LENGTH];
  sum_t       sum_q [NUM_CHANNELS];
  sum_t       sum_next [NUM_CHANNELS];

  //////////////////////////////////////////////////////////////////////
  // running sums
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      // add newcomer, drop the oldest
      sum_next[i] = sum_q[i] + sum_t'(mag_in.ch[i]) - sum_t'(hist_q[AVG_LENGTH-1].ch[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_CHANNELS; i++) begin
        sum_q[i] <= '0;
      end
      for (int j = 0; j < AVG_LENGTH; j++) begin
        hist_q[j] <= '0;
      end
      mag_out <= '0;
      avg     <= '0;
    end else if (step) begin
      for (int i = 0; i < NUM_CHANNELS; i++) begin
        sum_q[i] <= sum_next[i];
        // floor divide by window length
        avg.ch[i] <= mag_t'(sum_next[i] >> AVG_POWER);
      end
      hist_q[0] <= mag_in;
      for (int j = 1; j < AVG_LENGTH; j++) begin
        hist_q[j] <= hist_q[j-1];
      end
      mag_out <= mag_in;
    end
  end

  // raw frame only rides along
  always_ff @(posedge clk) begin
    if (step) begin
      raw_out <= raw_in;
    end
  end

  // sum always holds the oldest entry, so removing it cannot wrap
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_sum_check
    assert property (@(posedge clk) disable iff (!rst_n)
      sum_q[c] >= sum_t'(hist_q[AVG_LENGTH-1].ch[c]));
  end

endmodule

`default_nettype wire

// File: source/peak_trigger.sv
// one burst per rising peak edge; re-arms after BURST_LENGTH frames since reset or the last drain
`timescale 1ns/1ns
`default_nettype none

module peak_trigger
  import peak_cfg_pkg::*;
  import peak_types_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n,
  input  wire             step,
  input  wire frame_t     raw_in,
  input  wire mag_frame_t mag_in,
  input  wire mag_frame_t avg,
  input  wire             armed_clear,
  output frame_t          raw_out,
  output logic            burst_start
);

  // dly_q[0] newest, last entry is the window centre
  mag_frame_t              dly_q [CENTER_DELAY];
  thresh_t                 thresh [NUM_CHANNELS];
  logic [NUM_CHANNELS-1:0] peak;
  logic                    any_peak;
  logic                    prev_any_q;
  logic                    primed_q;
  count_t                  fill_cnt_q;
  count_t                  fill_cnt_next;

  //////////////////////////////////////////////////////////////////////
  // threshold compare
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < NUM_CHANNELS; i++) begin
      thresh[i] = (thresh_t'(avg.ch[i]) + thresh_t'(1)) << THRESH_SHIFT;
      // strictly above, equal does not count
      peak[i] = thresh_t'(dly_q[CENTER_DELAY-1].ch[i]) > thresh[i];
    end
  end

  assign any_peak = |peak;

  // count including the frame now entering, saturating
  assign fill_cnt_next = (fill_cnt_q == count_t'(BURST_LENGTH)) ? fill_cnt_q
                                                                : fill_cnt_q + 1'b1;

  //////////////////////////////////////////////////////////////////////
  // edge detect and arming
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      primed_q    <= 1'b0;
      prev_any_q  <= 1'b0;
      fill_cnt_q  <= '0;
      burst_start <= 1'b0;
      for (int j = 0; j < CENTER_DELAY; j++) begin
        dly_q[j] <= '0;
      end
    end else begin
      // single-cycle pulse for the frame latched this step
      burst_start <= step & primed_q & any_peak & ~prev_any_q &
                     (fill_cnt_next == count_t'(BURST_LENGTH));
      if (armed_clear) begin
        fill_cnt_q <= '0;
      end else if (step && primed_q) begin
        fill_cnt_q <= fill_cnt_next;
      end
      if (step) begin
        // first step only flushes the empty previous stage
        primed_q   <= 1'b1;
        prev_any_q <= any_peak;
        dly_q[0]   <= mag_in;
        for (int j = 1; j < CENTER_DELAY; j++) begin
          dly_q[j] <= dly_q[j-1];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (step) begin
      raw_out <= raw_in;
    end
  end

  // no burst before enough history has gone by
  assert property (@(posedge clk) disable iff (!rst_n)
    burst_start |-> fill_cnt_q == count_t'(BURST_LENGTH));

endmodule

`default_nettype wire

// File: source/burst_capture.sv
// buffer holds the last BURST_LENGTH trigger-stage frames; input is held off until out_last transfers
`timescale 1ns/1ns
`default_nettype none

module burst_capture
  import peak_cfg_pkg::*;
  import peak_types_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n,
  input  wire         step,
  input  wire frame_t raw_in,
  input  wire         burst_start,
  input  wire         out_ready,
  output logic        hold,
  output logic        armed_clear,
  output logic        out_valid,
  output frame_t      out_frame,
  output logic        out_last
);

  capture_state_t state_q;
  count_t         drain_cnt_q;
  // buf_q[0] newest, last entry oldest
  frame_t         buf_q [BURST_LENGTH];
  logic           xfer;
  logic           fill_shift;

  //////////////////////////////////////////////////////////////////////
  // output stream
  //////////////////////////////////////////////////////////////////////

  assign out_valid = (state_q == DRAIN);
  // oldest first
  assign out_frame = buf_q[BURST_LENGTH-1];
  assign out_last  = out_valid && (drain_cnt_q == count_t'(BURST_LENGTH - 1));
  assign xfer      = out_valid & out_ready;

  // arming restarts as the burst closes
  assign armed_clear = xfer & out_last;

  // held off already in the trigger cycle so no frame steps mid-drain
  assign hold = out_valid | burst_start;

  // trigger frame is still in the previous stage, take it with burst_start
  assign fill_shift = (state_q == FILL) & (step | burst_start);

  //////////////////////////////////////////////////////////////////////
  // fill / drain FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= FILL;
      drain_cnt_q <= '0;
    end else begin
      case (state_q)
        FILL: begin
          if (burst_start) begin
            state_q <= DRAIN;
          end
          drain_cnt_q <= '0;
        end
        DRAIN: begin
          if (xfer) begin
            if (out_last) begin
              state_q     <= FILL;
              drain_cnt_q <= '0;
            end else begin
              drain_cnt_q <= drain_cnt_q + 1'b1;
            end
          end
        end
        default: begin
          state_q <= FILL;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // history buffer
  //////////////////////////////////////////////////////////////////////

  // one shift register serves both filling and draining
  always_ff @(posedge clk) begin
    if (fill_shift || xfer) begin
      buf_q[0] <= raw_in;
      for (int j = 1; j < BURST_LENGTH; j++) begin
        buf_q[j] <= buf_q[j-1];
      end
    end
  end

  // pipeline stays frozen for the whole drain
  assert property (@(posedge clk) disable iff (!rst_n)
    state_q == DRAIN |-> !step);

  // stalled output keeps valid and data
  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_frame));

endmodule

`default_nettype wire

// File: source/peak_detect_top.sv
// four-channel peak detector; no input is taken while a burst drains
`timescale 1ns/1ns
`default_nettype none

module peak_detect_top
  import peak_types_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n,
  input  wire         in_valid,
  output wire         in_ready,
  input  wire frame_t in_frame,
  output wire         out_valid,
  input  wire         out_ready,
  output wire frame_t out_frame,
  output wire         out_last
);

  // pipeline advance and capture feedback
  wire step;
  wire hold;
  wire armed_clear;
  wire burst_start;

  // stage outputs
  wire frame_t     ing_raw;
  wire mag_frame_t ing_mag;
  wire frame_t     box_raw;
  wire mag_frame_t box_mag;
  wire mag_frame_t box_avg;
  wire frame_t     trig_raw;

  //////////////////////////////////////////////////////////////////////
  // stage chain
  //////////////////////////////////////////////////////////////////////

  sample_ingress u_ingress (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_frame (in_frame),
    .hold     (hold),
    .in_ready (in_ready),
    .step     (step),
    .raw      (ing_raw),
    .mag      (ing_mag)
  );

  boxcar_average u_boxcar (
    .clk     (clk),
    .rst_n   (rst_n),
    .step    (step),
    .raw_in  (ing_raw),
    .mag_in  (ing_mag),
    .raw_out (box_raw),
    .mag_out (box_mag),
    .avg     (box_avg)
  );

  peak_trigger u_trigger (
    .clk         (clk),
    .rst_n       (rst_n),
    .step        (step),
    .raw_in      (box_raw),
    .mag_in      (box_mag),
    .avg         (box_avg),
    .armed_clear (armed_clear),
    .raw_out     (trig_raw),
    .burst_start (burst_start)
  );

  // hold and armed_clear run back up the chain
  burst_capture u_capture (
    .clk         (clk),
    .rst_n       (rst_n),
    .step        (step),
    .raw_in      (trig_raw),
    .burst_start (burst_start),
    .out_ready   (out_ready),
    .hold        (hold),
    .armed_clear (armed_clear),
    .out_valid   (out_valid),
    .out_frame   (out_frame),
    .out_last    (out_last)
  );

endmodule

`default_nettype wire

// File: sim/peak_checker.sv
// model holds at most MAX_FRAMES accepted frames; ports are sampled on the falling clock edge
`timescale 1ns/1ns
`default_nettype none

module peak_checker
  import peak_cfg_pkg::*;
  import peak_types_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n,
  input  wire         in_valid,
  input  wire         in_ready,
  input  wire frame_t in_frame,
  input  wire         out_valid,
  input  wire         out_ready,
  input  wire frame_t out_frame,
  input  wire         out_last,
  output int          error_count,
  output int          pending,
  output int          bursts_expected,
  output int          bursts_seen
);

  localparam int MAX_FRAMES = 1024;

  // full input history, indexed by acceptance order
  frame_t raw_hist [MAX_FRAMES];
  int     mag_hist [MAX_FRAMES][NUM_CHANNELS];
  // expected burst frames, oldest first
  frame_t exp_frame_q [$];
  logic   exp_last_q [$];

  int   errors     = 0;
  int   frames     = 0;
  int   arm_count  = 0;
  int   exp_bursts = 0;
  int   seen       = 0;
  int   queued     = 0;
  logic any_prev   = 1'b0;
  // in_ready low without out_valid, a drain must follow
  logic ready_low_q = 1'b0;

  assign error_count     = errors;
  assign pending         = queued;
  assign bursts_expected = exp_bursts;
  assign bursts_seen     = seen;

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // absolute value, most negative code clipped to the top positive one
  function automatic int sample_mag(input int s);
    int m;
    m = (s < 0) ? -s : s;
    if (m > (1 << (SAMPLE_WIDTH - 1)) - 1) begin
      m = (1 << (SAMPLE_WIDTH - 1)) - 1;
    end
    return m;
  endfunction

  // any channel of frame k shows a peak at the window centre
  function automatic logic expected_peak(input int k);
    int   sum;
    int   centre;
    logic hit;
    hit = 1'b0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      sum = 0;
      // frames before the first one count as zero
      for (int j = k - AVG_LENGTH + 1; j <= k; j++) begin
        if (j >= 0) begin
          sum += mag_hist[j][c];
        end
      end
      centre = (k >= CENTER_DELAY) ? mag_hist[k - CENTER_DELAY][c] : 0;
      if (centre > ((sum / AVG_LENGTH) + 1) * (1 << THRESH_SHIFT)) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare and feed the model
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : compare
    frame_t exp_f;
    logic   exp_l;
    logic   now_peak;
    if (rst_n) begin
      // input stall only while a burst is owed
      if (!in_ready && exp_frame_q.size() == 0) begin
        $display("in_ready is low although no burst is pending");
        errors++;
      end
      if (ready_low_q && !out_valid) begin
        $display("in_ready dropped but no output burst followed");
        errors++;
      end
      ready_low_q = !in_ready && !out_valid;
      if (out_valid && out_ready) begin
        if (exp_frame_q.size() == 0) begin
          $display("output frame %h arrived while no burst was expected", out_frame);
          errors++;
        end else begin
          exp_f = exp_frame_q.pop_front();
          exp_l = exp_last_q.pop_front();
          if (out_frame !== exp_f) begin
            $display("Mismatch out_frame: expected %h, got %h", exp_f, out_frame);
            errors++;
          end
          if (out_last !== exp_l) begin
            $display("Mismatch out_last: expected %h, got %h", exp_l, out_last);
            errors++;
          end
          if (out_last) begin
            seen++;
          end
        end
      end
      if (in_valid && in_ready) begin
        if (frames >= MAX_FRAMES) begin
          $display("more input frames than the reference model can hold");
          errors++;
        end else begin
          raw_hist[frames] = in_frame;
          for (int c = 0; c < NUM_CHANNELS; c++) begin
            mag_hist[frames][c] = sample_mag(int'(in_frame.ch[c]));
          end
          now_peak = expected_peak(frames);
          if (arm_count < BURST_LENGTH) begin
            arm_count++;
          end
          // rising edge while armed starts a burst of the last 16 frames
          if (now_peak && !any_prev && arm_count == BURST_LENGTH) begin
            for (int j = frames - BURST_LENGTH + 1; j <= frames; j++) begin
              exp_frame_q.push_back(raw_hist[j]);
              exp_last_q.push_back(j == frames);
            end
            arm_count = 0;
            exp_bursts++;
          end
          any_prev = now_peak;
          frames++;
        end
      end
      queued = exp_frame_q.size();
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_peak_detect.sv
// random in_valid and out_ready with seed 32890; expects exactly eight bursts from its stimulus
`timescale 1ns/1ns
`default_nettype none

module tb_peak_detect;

  import peak_cfg_pkg::*;
  import peak_types_pkg::*;

  // spikes in the stimulus below that should start a burst
  localparam int BURSTS_PLANNED = 8;

  logic   clk = 1'b0;
  logic   rst_n;
  logic   in_valid;
  logic   in_ready;
  frame_t in_frame;
  logic   out_valid;
  logic   out_ready;
  frame_t out_frame;
  logic   out_last;

  int     seed;
  frame_t stim_q [$];
  int     n_frames;
  int     idx;
  int     settle;
  logic   accepted;
  int     cycles = 0;
  int     cycle_limit = 0;
  int     end_errors;
  int     error_count;
  int     pending;
  int     bursts_expected;
  int     bursts_seen;

  always #4 clk = ~clk;

  peak_detect_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_frame  (in_frame),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_frame (out_frame),
    .out_last  (out_last)
  );

  peak_checker u_checker (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_valid        (in_valid),
    .in_ready        (in_ready),
    .in_frame        (in_frame),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .out_frame       (out_frame),
    .out_last        (out_last),
    .error_count     (error_count),
    .pending         (pending),
    .bursts_expected (bursts_expected),
    .bursts_seen     (bursts_seen)
  );

  //////////////////////////////////////////////////////////////////////
  // stimulus frames
  //////////////////////////////////////////////////////////////////////

  // tiny noise of either sign or exact zeros as baseline
  task automatic add_quiet(input int count, input bit noisy);
    frame_t f;
    for (int i = 0; i < count; i++) begin
      for (int c = 0; c < NUM_CHANNELS; c++) begin
        f.ch[c] = noisy ? sample_t'($random(seed) % 8) : '0;
      end
      stim_q.push_back(f);
    end
  endtask

  // one large sample on a single channel
  task automatic add_spike(input int ch, input int value, input bit noisy);
    frame_t f;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      f.ch[c] = noisy ? sample_t'($random(seed) % 8) : '0;
    end
    f.ch[ch] = sample_t'(value);
    stim_q.push_back(f);
  endtask

  task automatic build_stimulus();
    // quiet start, then one clear spike
    add_quiet(40, 1'b1);
    add_spike(2, 30000, 1'b1);
    add_quiet(30, 1'b1);
    // zero baseline where 8 sits on the threshold and 9 is above
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      add_quiet(24, 1'b0);
      add_spike(c, (c % 2 == 0) ? -8 : 8, 1'b0);
      add_quiet(24, 1'b0);
      add_spike(c, (c % 2 == 0) ? 9 : -9, 1'b0);
    end
    // saturated most negative sample
    add_quiet(24, 1'b0);
    add_spike(3, -32768, 1'b0);
    add_quiet(24, 1'b0);
    // back-to-back peaks and an early one before re-arm
    add_spike(0, 30000, 1'b0);
    add_spike(1, -30000, 1'b0);
    add_quiet(8, 1'b0);
    add_spike(2, 25000, 1'b0);
    add_quiet(4, 1'b0);
    // second peak of this pair lands on the first armed frame
    // but is no rising edge
    add_spike(0, 20000, 1'b0);
    add_spike(1, -20000, 1'b0);
    add_quiet(23, 1'b0);
    // late spike, armed again
    add_spike(3, 30000, 1'b0);
    add_quiet(30, 1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // drive, wait for the drains, report
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_frame  = '0;
    out_ready = 1'b0;
    seed      = 32890;
    idx       = 0;
    settle    = 0;
    build_stimulus();
    n_frames    = stim_q.size();
    cycle_limit = 4 * n_frames + 200;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    while (!(idx >= n_frames && pending == 0 && settle >= 40)) begin
      @(posedge clk);
      accepted = in_valid && in_ready;
      if (accepted) begin
        idx = idx + 1;
      end
      // valid stays up with the same frame until taken
      if (idx >= n_frames) begin
        in_valid <= 1'b0;
      end else if (!in_valid || accepted) begin
        in_valid <= ($random(seed) % 4) != 0;
      end
      if (idx < n_frames) begin
        in_frame <= stim_q[idx];
      end
      out_ready <= ($random(seed) % 3) != 0;
      if (idx >= n_frames && pending == 0) begin
        settle = settle + 1;
      end else begin
        settle = 0;
      end
    end
    end_errors = 0;
    if (bursts_expected != BURSTS_PLANNED) begin
      $display("model predicted %0d bursts, stimulus holds %0d",
               bursts_expected, BURSTS_PLANNED);
      end_errors++;
    end
    if (bursts_seen != bursts_expected) begin
      $display("DUT delivered %0d bursts, model expected %0d", bursts_seen, bursts_expected);
      end_errors++;
    end
    $display("checker errors %0d, end errors %0d, bursts %0d of %0d, frames %0d",
             error_count, end_errors, bursts_seen, bursts_expected, n_frames);
    if (error_count == 0 && end_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // run length bound from the stimulus size
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("run timed out after %0d cycles, errors %0d, %0d expected frames pending",
               cycles, error_count, pending);
      $display("** FAIL **");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: list.f
source/peak_cfg_pkg.sv
source/peak_types_pkg.sv
source/sample_ingress.sv
source/boxcar_average.sv
source/peak_trigger.sv
source/burst_capture.sv
source/peak_detect_top.sv
sim/peak_checker.sv
sim/tb_peak_detect.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_peak_detect -o tb_peak_detect > build.log 2>&1 \
  && ./obj_dir/tb_peak_detect > sim.log 2>&1 \
  ; grep -qxF '** PASS **' sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }
